// File: logic/rx_pcs_pkg.sv
/* Shared constants and types for the four-lane 10GBASE-R receive core.
   Modules refer to these by scoped name. */
`default_nettype none

package rx_pcs_pkg;

    // Lane geometry
    localparam int NUM_LANES = 4;
    localparam int BLOCK_W   = 64;
    localparam int HDR_W     = 2;
    localparam int CTRL_W    = 8;

    // Self-synchronous descrambler x^58 + x^39 + 1
    localparam int SCR_DELAY = 58;
    localparam int SCR_TAP   = 39;

    localparam int ERR_CNT_W = 8;

    // Sync header codes
    localparam logic [HDR_W-1:0] HDR_DATA = 2'b01;
    localparam logic [HDR_W-1:0] HDR_CTRL = 2'b10;

    // Block type field values
    localparam logic [7:0] BT_IDLE  = 8'h1E;
    localparam logic [7:0] BT_START = 8'h78;

    // Terminate codes, entry k is Tk
    localparam logic [CTRL_W-1:0][7:0] BT_TERM = {
        8'hFF, 8'hE1, 8'hD2, 8'hCC, 8'hB4, 8'hAA, 8'h99, 8'h87
    };

    // XGMII control characters
    localparam logic [7:0] XG_IDLE  = 8'h07;
    localparam logic [7:0] XG_START = 8'hFB;
    localparam logic [7:0] XG_TERM  = 8'hFD;
    localparam logic [7:0] XG_ERROR = 8'hFE;

    // One decoded lane
    typedef struct packed {
        logic [BLOCK_W-1:0] data;
        logic [CTRL_W-1:0]  ctrl;
        logic               err;
        logic               term;
    } lane_dec_t;

endpackage

`default_nettype wire

// File: logic/lane_block_capture.sv
/* Input register for one word of 66-bit blocks.
   Flags lanes whose sync header is 00 or 11. */
`timescale 1ns/1ps
`default_nettype none

module lane_block_capture #(
    parameter int num_lanes = 4
) (
    input  wire logic                                          rx_clk_161_13,
    input  wire logic                                          async_reset_n,
    input  wire logic                                          block_valid_i,
    input  wire logic [num_lanes-1:0][rx_pcs_pkg::HDR_W-1:0]   rx_header_i,
    input  wire logic [num_lanes-1:0][rx_pcs_pkg::BLOCK_W-1:0] rx_data_i,
    output logic                                               cap_valid_o,
    output logic [num_lanes-1:0][rx_pcs_pkg::HDR_W-1:0]        cap_header_o,
    output logic [num_lanes-1:0][rx_pcs_pkg::BLOCK_W-1:0]      cap_data_o,
    output logic [num_lanes-1:0]                               cap_bad_hdr_o
);

    logic [num_lanes-1:0] bad_hdr;

    // Both header bits equal means no valid sync
    always_comb begin
        for (int l = 0; l < num_lanes; l++) begin
            bad_hdr[l] = (rx_header_i[l][0] == rx_header_i[l][1]);
        end
    end

    //////////////////////////////////////////////////
    // Valid strobe
    //////////////////////////////////////////////////
    always_ff @(posedge rx_clk_161_13) begin
        if (!async_reset_n) begin
            cap_valid_o <= 1'b0;
        end else begin
            cap_valid_o <= block_valid_i;
        end
    end

    //////////////////////////////////////////////////
    // Payload, loaded on valid words only
    //////////////////////////////////////////////////
    always_ff @(posedge rx_clk_161_13) begin
        if (block_valid_i) begin
            cap_header_o  <= rx_header_i;
            cap_data_o    <= rx_data_i;
            cap_bad_hdr_o <= bad_hdr;
        end
    end

endmodule

`default_nettype wire

// File: logic/parallel_descrambler.sv
/* Four-lane parallel x^58 + x^39 + 1 descrambler.
   Each lane takes its history from the lane below; lane 0 uses the held
   lane 3 payload of the last valid word. */
`timescale 1ns/1ps
`default_nettype none

module parallel_descrambler #(
    parameter int num_lanes = 4
) (
    input  wire logic                                          rx_clk_161_13,
    input  wire logic                                          async_reset_n,
    input  wire logic                                          cap_valid_i,
    input  wire logic [num_lanes-1:0][rx_pcs_pkg::HDR_W-1:0]   cap_header_i,
    input  wire logic [num_lanes-1:0][rx_pcs_pkg::BLOCK_W-1:0] cap_data_i,
    input  wire logic [num_lanes-1:0]                          cap_bad_hdr_i,
    input  wire logic                                          bypass_i,
    output logic                                               dsc_valid_o,
    output logic [num_lanes-1:0][rx_pcs_pkg::HDR_W-1:0]        dsc_header_o,
    output logic [num_lanes-1:0][rx_pcs_pkg::BLOCK_W-1:0]      dsc_data_o,
    output logic [num_lanes-1:0]                               dsc_bad_hdr_o
);

    localparam int bw     = rx_pcs_pkg::BLOCK_W;
    // Low ends of the two tap windows in {current, previous}
    localparam int tap_lo = bw - rx_pcs_pkg::SCR_TAP;
    localparam int dly_lo = bw - rx_pcs_pkg::SCR_DELAY;

    logic [bw-1:0]                 hist;
    logic [num_lanes-1:0][bw-1:0]  prev_data;
    logic [num_lanes-1:0][bw-1:0]  descr;

    //////////////////////////////////////////////////
    // Per-lane descramble
    //////////////////////////////////////////////////
    for (genvar l = 0; l < num_lanes; l++) begin : g_lane
        logic [2*bw-1:0] ext;

        if (l == 0) begin : g_first
            assign prev_data[l] = hist;
        end else begin : g_chain
            assign prev_data[l] = cap_data_i[l-1];
        end

        // Scrambled stream, older bits at the bottom
        assign ext = {cap_data_i[l], prev_data[l]};

        assign descr[l] = cap_data_i[l] ^ ext[tap_lo +: bw] ^ ext[dly_lo +: bw];
    end

    //////////////////////////////////////////////////
    // Control state
    //////////////////////////////////////////////////
    always_ff @(posedge rx_clk_161_13) begin
        if (!async_reset_n) begin
            dsc_valid_o <= 1'b0;
            hist        <= '0;
        end else begin
            dsc_valid_o <= cap_valid_i;
            // History moves even in bypass
            if (cap_valid_i) begin
                hist <= cap_data_i[num_lanes-1];
            end
        end
    end

    // Output payload
    always_ff @(posedge rx_clk_161_13) begin
        if (cap_valid_i) begin
            dsc_header_o  <= cap_header_i;
            dsc_bad_hdr_o <= cap_bad_hdr_i;
            dsc_data_o    <= bypass_i ? cap_data_i : descr;
        end
    end

endmodule

`default_nettype wire

// File: logic/block_decoder.sv
/* Combinational 66b to XGMII decoder for a single lane.
   Gives 8 data bytes, 8 control bits and error / terminate flags. */
`timescale 1ns/1ps
`default_nettype none

module block_decoder (
    input  wire logic [rx_pcs_pkg::HDR_W-1:0]   header_i,
    input  wire logic [rx_pcs_pkg::BLOCK_W-1:0] data_i,
    input  wire logic                           bad_hdr_i,
    output rx_pcs_pkg::lane_dec_t               lane_o
);

    localparam int bw = rx_pcs_pkg::BLOCK_W;
    localparam int cw = rx_pcs_pkg::CTRL_W;

    logic [7:0]          block_type;
    logic [bw-1:0]       term_payload;
    logic                is_term;
    logic [2:0]          term_pos;

    // Type byte goes out first
    assign block_type = data_i[7:0];

    // Payload bytes after the type field, moved down to byte 0
    assign term_payload = {8'h00, data_i[bw-1:8]};

    //////////////////////////////////////////////////
    // Terminate code lookup
    //////////////////////////////////////////////////
    always_comb begin
        is_term  = 1'b0;
        term_pos = '0;
        for (int k = 0; k < cw; k++) begin
            if (block_type == rx_pcs_pkg::BT_TERM[k]) begin
                is_term  = 1'b1;
                term_pos = 3'(k);
            end
        end
    end

    //////////////////////////////////////////////////
    // Decode
    //////////////////////////////////////////////////
    always_comb begin
        // Error block unless a rule below matches
        lane_o.data = {cw{rx_pcs_pkg::XG_ERROR}};
        lane_o.ctrl = '1;
        lane_o.err  = 1'b1;
        lane_o.term = 1'b0;

        if (!bad_hdr_i && header_i == rx_pcs_pkg::HDR_DATA) begin
            lane_o.data = data_i;
            lane_o.ctrl = '0;
            lane_o.err  = 1'b0;
        end else if (!bad_hdr_i) begin
            // Only the control header remains
            if (block_type == rx_pcs_pkg::BT_IDLE) begin
                lane_o.data = {cw{rx_pcs_pkg::XG_IDLE}};
                lane_o.ctrl = '1;
                lane_o.err  = 1'b0;
            end else if (block_type == rx_pcs_pkg::BT_START) begin
                lane_o.data = {data_i[bw-1:8], rx_pcs_pkg::XG_START};
                lane_o.ctrl = 8'h01;
                lane_o.err  = 1'b0;
            end else if (is_term) begin
                lane_o.err  = 1'b0;
                lane_o.term = 1'b1;
                // Tk: k data bytes, terminate, then idle fill
                for (int j = 0; j < cw; j++) begin
                    if (j < int'(term_pos)) begin
                        lane_o.data[8*j +: 8] = term_payload[8*j +: 8];
                        lane_o.ctrl[j]        = 1'b0;
                    end else if (j == int'(term_pos)) begin
                        lane_o.data[8*j +: 8] = rx_pcs_pkg::XG_TERM;
                        lane_o.ctrl[j]        = 1'b1;
                    end else begin
                        lane_o.data[8*j +: 8] = rx_pcs_pkg::XG_IDLE;
                        lane_o.ctrl[j]        = 1'b1;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/xgmii_word_assembler.sv
/* Output stage of the receive core. Applies the terminate chain across lanes,
   registers the XGMII word and keeps the saturating errored-block count. */
`timescale 1ns/1ps
`default_nettype none

module xgmii_word_assembler #(
    parameter int num_lanes = 4
) (
    input  wire logic                                        rx_clk_161_13,
    input  wire logic                                        async_reset_n,
    input  wire logic                                        dsc_valid_i,
    input  wire rx_pcs_pkg::lane_dec_t [num_lanes-1:0]       lanes_i,
    input  wire logic                                        clear_errblk_i,
    output logic [num_lanes-1:0][rx_pcs_pkg::BLOCK_W-1:0]    xgmii_rxd_o,
    output logic [num_lanes-1:0][rx_pcs_pkg::CTRL_W-1:0]     xgmii_rxc_o,
    output logic                                             xgmii_valid_o,
    output logic [rx_pcs_pkg::ERR_CNT_W-1:0]                 errd_blks_o
);

    localparam int bw     = rx_pcs_pkg::BLOCK_W;
    localparam int cw     = rx_pcs_pkg::CTRL_W;
    localparam int errs_w = $clog2(num_lanes + 1);
    localparam int sum_w  = rx_pcs_pkg::ERR_CNT_W + 1;

    logic [num_lanes-1:0][bw-1:0] word_rxd;
    logic [num_lanes-1:0][cw-1:0] word_rxc;
    logic [num_lanes-1:0]         lane_err;
    logic                         term_seen;
    logic [errs_w-1:0]            word_errs;
    logic [sum_w-1:0]             cnt_sum;

    //////////////////////////////////////////////////
    // Terminate chain and error tally
    //////////////////////////////////////////////////
    always_comb begin
        term_seen = 1'b0;
        word_errs = '0;
        for (int l = 0; l < num_lanes; l++) begin
            // Data after a lower-lane terminate is an error
            lane_err[l] = lanes_i[l].err || (term_seen && lanes_i[l].ctrl == '0);
            if (lane_err[l]) begin
                word_rxd[l] = {cw{rx_pcs_pkg::XG_ERROR}};
                word_rxc[l] = '1;
            end else begin
                word_rxd[l] = lanes_i[l].data;
                word_rxc[l] = lanes_i[l].ctrl;
            end
            word_errs = word_errs + errs_w'(lane_err[l]);
            term_seen = term_seen | lanes_i[l].term;
        end
    end

    assign cnt_sum = sum_w'(errd_blks_o) + sum_w'(word_errs);

    //////////////////////////////////////////////////
    // Output word
    //////////////////////////////////////////////////
    always_ff @(posedge rx_clk_161_13) begin
        if (!async_reset_n) begin
            xgmii_valid_o <= 1'b0;
            xgmii_rxd_o   <= {(num_lanes * cw){rx_pcs_pkg::XG_IDLE}};
            xgmii_rxc_o   <= '1;
        end else begin
            xgmii_valid_o <= dsc_valid_i;
            if (dsc_valid_i) begin
                xgmii_rxd_o <= word_rxd;
                xgmii_rxc_o <= word_rxc;
            end
        end
    end

    // Errored-block counter, clear wins
    always_ff @(posedge rx_clk_161_13) begin
        if (!async_reset_n) begin
            errd_blks_o <= '0;
        end else if (clear_errblk_i) begin
            errd_blks_o <= '0;
        end else if (dsc_valid_i) begin
            if (cnt_sum[sum_w-1]) begin
                errd_blks_o <= '1;
            end else begin
                errd_blks_o <= cnt_sum[sum_w-2:0];
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/rx_pcs_top.sv
/* Top level of the four-lane 10GBASE-R receive path.
   Capture, descramble, decode and assemble, three cycles from input to XGMII. */
`timescale 1ns/1ps
`default_nettype none

module rx_pcs_top #(
    parameter int num_lanes = rx_pcs_pkg::NUM_LANES
) (
    input  wire logic                                          rx_clk_161_13,
    input  wire logic                                          async_reset_n,
    input  wire logic                                          block_valid_i,
    input  wire logic [num_lanes-1:0][rx_pcs_pkg::HDR_W-1:0]   rx_header_i,
    input  wire logic [num_lanes-1:0][rx_pcs_pkg::BLOCK_W-1:0] rx_data_i,
    input  wire logic                                          bypass_descram_i,
    input  wire logic                                          clear_errblk_i,
    output logic [num_lanes-1:0][rx_pcs_pkg::BLOCK_W-1:0]      xgmii_rxd_o,
    output logic [num_lanes-1:0][rx_pcs_pkg::CTRL_W-1:0]       xgmii_rxc_o,
    output logic                                               xgmii_valid_o,
    output logic [rx_pcs_pkg::ERR_CNT_W-1:0]                   errd_blks_o
);

    logic                                          cap_valid;
    logic [num_lanes-1:0][rx_pcs_pkg::HDR_W-1:0]   cap_header;
    logic [num_lanes-1:0][rx_pcs_pkg::BLOCK_W-1:0] cap_data;
    logic [num_lanes-1:0]                          cap_bad_hdr;

    logic                                          dsc_valid;
    logic [num_lanes-1:0][rx_pcs_pkg::HDR_W-1:0]   dsc_header;
    logic [num_lanes-1:0][rx_pcs_pkg::BLOCK_W-1:0] dsc_data;
    logic [num_lanes-1:0]                          dsc_bad_hdr;

    rx_pcs_pkg::lane_dec_t [num_lanes-1:0]         dec_lanes;

    lane_block_capture #(.num_lanes(num_lanes)) u_capture (
        .rx_clk_161_13 (rx_clk_161_13),
        .async_reset_n (async_reset_n),
        .block_valid_i (block_valid_i),
        .rx_header_i   (rx_header_i),
        .rx_data_i     (rx_data_i),
        .cap_valid_o   (cap_valid),
        .cap_header_o  (cap_header),
        .cap_data_o    (cap_data),
        .cap_bad_hdr_o (cap_bad_hdr)
    );

    parallel_descrambler #(.num_lanes(num_lanes)) u_descram (
        .rx_clk_161_13 (rx_clk_161_13),
        .async_reset_n (async_reset_n),
        .cap_valid_i   (cap_valid),
        .cap_header_i  (cap_header),
        .cap_data_i    (cap_data),
        .cap_bad_hdr_i (cap_bad_hdr),
        .bypass_i      (bypass_descram_i),
        .dsc_valid_o   (dsc_valid),
        .dsc_header_o  (dsc_header),
        .dsc_data_o    (dsc_data),
        .dsc_bad_hdr_o (dsc_bad_hdr)
    );

    // One decoder per lane, no added cycle
    for (genvar l = 0; l < num_lanes; l++) begin : g_dec
        block_decoder u_dec (
            .header_i  (dsc_header[l]),
            .data_i    (dsc_data[l]),
            .bad_hdr_i (dsc_bad_hdr[l]),
            .lane_o    (dec_lanes[l])
        );
    end

    xgmii_word_assembler #(.num_lanes(num_lanes)) u_assembler (
        .rx_clk_161_13  (rx_clk_161_13),
        .async_reset_n  (async_reset_n),
        .dsc_valid_i    (dsc_valid),
        .lanes_i        (dec_lanes),
        .clear_errblk_i (clear_errblk_i),
        .xgmii_rxd_o    (xgmii_rxd_o),
        .xgmii_rxc_o    (xgmii_rxc_o),
        .xgmii_valid_o  (xgmii_valid_o),
        .errd_blks_o    (errd_blks_o)
    );

endmodule

`default_nettype wire

// File: tb/rx_pcs_asserts.sv
/* Concurrent checks on the receive core ports, bound into rx_pcs_top.
   Reset state, three-cycle latency, bypass and the errored-block counter. */
`timescale 1ns/1ps
`default_nettype none

module rx_pcs_asserts #(
    parameter int num_lanes = 4
) (
    input wire logic                                          rx_clk_161_13,
    input wire logic                                          async_reset_n,
    input wire logic                                          block_valid_i,
    input wire logic [num_lanes-1:0][rx_pcs_pkg::HDR_W-1:0]   rx_header_i,
    input wire logic [num_lanes-1:0][rx_pcs_pkg::BLOCK_W-1:0] rx_data_i,
    input wire logic                                          bypass_descram_i,
    input wire logic                                          clear_errblk_i,
    input wire logic [num_lanes-1:0][rx_pcs_pkg::BLOCK_W-1:0] xgmii_rxd_o,
    input wire logic [num_lanes-1:0][rx_pcs_pkg::CTRL_W-1:0]  xgmii_rxc_o,
    input wire logic                                          xgmii_valid_o,
    input wire logic [rx_pcs_pkg::ERR_CNT_W-1:0]              errd_blks_o
);

    localparam int cw      = rx_pcs_pkg::CTRL_W;
    localparam int cnt_max = (1 << rx_pcs_pkg::ERR_CNT_W) - 1;

    int unsigned fail_count = 0;

    // Lanes shown as eight error characters
    function automatic int error_lanes(
        input logic [num_lanes-1:0][rx_pcs_pkg::BLOCK_W-1:0] rxd,
        input logic [num_lanes-1:0][cw-1:0]                  rxc
    );
        int n;
        n = 0;
        for (int l = 0; l < num_lanes; l++) begin
            if (rxc[l] == '1 && rxd[l] == {cw{rx_pcs_pkg::XG_ERROR}}) begin
                n++;
            end
        end
        return n;
    endfunction

    function automatic int saturated_sum(input int base, input int add);
        return (base + add > cnt_max) ? cnt_max : base + add;
    endfunction

    //////////////////////////////////////////////////
    // Reset and latency
    //////////////////////////////////////////////////
    a_reset_idle: assert property (@(posedge rx_clk_161_13)
        (!async_reset_n || $rose(async_reset_n)) |=> (!xgmii_valid_o && errd_blks_o == '0
            && xgmii_rxc_o == '1 && xgmii_rxd_o == {(num_lanes * cw){rx_pcs_pkg::XG_IDLE}}))
        else begin
            fail_count++;
            $error("XGMII outputs not idle during or right after reset");
        end

    a_latency: assert property (@(posedge rx_clk_161_13) disable iff (!async_reset_n)
        xgmii_valid_o == $past(block_valid_i, 3))
        else begin
            fail_count++;
            $error("xgmii_valid_o is not block_valid_i delayed by three cycles");
        end

    // Raw payload passes straight through in bypass
    a_bypass: assert property (@(posedge rx_clk_161_13) disable iff (!async_reset_n)
        (xgmii_valid_o && $past(bypass_descram_i, 2)
            && $past(rx_header_i, 3) == {num_lanes{rx_pcs_pkg::HDR_DATA}})
        |-> (xgmii_rxd_o == $past(rx_data_i, 3) && xgmii_rxc_o == '0))
        else begin
            fail_count++;
            $error("bypass word differs from the raw input payload");
        end

    //////////////////////////////////////////////////
    // Errored-block counter
    //////////////////////////////////////////////////
    a_count_add: assert property (@(posedge rx_clk_161_13) disable iff (!async_reset_n)
        (xgmii_valid_o && !$past(clear_errblk_i)) |-> int'(errd_blks_o) == saturated_sum(
            int'($past(errd_blks_o)), error_lanes(xgmii_rxd_o, xgmii_rxc_o)))
        else begin
            fail_count++;
            $error("errd_blks_o did not add the errored lanes of the word");
        end

    a_count_hold: assert property (@(posedge rx_clk_161_13) disable iff (!async_reset_n)
        (!xgmii_valid_o && !$past(clear_errblk_i)) |-> errd_blks_o == $past(errd_blks_o))
        else begin
            fail_count++;
            $error("errd_blks_o changed without a valid word");
        end

    a_count_clear: assert property (@(posedge rx_clk_161_13) disable iff (!async_reset_n)
        $past(clear_errblk_i) |-> errd_blks_o == '0)
        else begin
            fail_count++;
            $error("errd_blks_o not zero after a clear");
        end

endmodule

bind rx_pcs_top rx_pcs_asserts #(.num_lanes(num_lanes)) u_asserts (.*);

`default_nettype wire

// File: tb/rx_pcs_tb.sv
/* Testbench for the four-lane receive core. Sends scrambled data, control,
   bypass and bad-header words and checks every XGMII word against a model. */
`timescale 1ns/1ps
`default_nettype none

module rx_pcs_tb;

    localparam int nl = rx_pcs_pkg::NUM_LANES;
    // About 200 cycles of stimulus, doubled for the limit
    localparam int max_cycles = 400;

    // Lane kinds, bit 3 marks terminate Tk with k in the low bits
    localparam logic [3:0] kind_data  = 4'd0;
    localparam logic [3:0] kind_idle  = 4'd1;
    localparam logic [3:0] kind_start = 4'd2;
    localparam logic [3:0] kind_bad00 = 4'd3;
    localparam logic [3:0] kind_bad11 = 4'd4;
    localparam logic [3:0] kind_term0 = 4'd8;

    logic                                        rx_clk_161_13 = 1'b0;
    logic                                        async_reset_n;
    logic                                        block_valid_i;
    logic [nl-1:0][rx_pcs_pkg::HDR_W-1:0]        rx_header_i;
    logic [nl-1:0][rx_pcs_pkg::BLOCK_W-1:0]      rx_data_i;
    logic                                        bypass_descram_i;
    logic                                        clear_errblk_i;
    logic [nl-1:0][rx_pcs_pkg::BLOCK_W-1:0]      xgmii_rxd_o;
    logic [nl-1:0][rx_pcs_pkg::CTRL_W-1:0]       xgmii_rxc_o;
    logic                                        xgmii_valid_o;
    logic [rx_pcs_pkg::ERR_CNT_W-1:0]            errd_blks_o;

    logic [31:0]     lcg_state;
    logic [63:0]     wire_hist;
    // {check, rxc, rxd} per expected word
    logic [nl*72:0]  exp_q[$];
    logic [nl*72:0]  got;
    int              words_sent = 0;
    int              words_seen = 0;
    int              cycles = 0;

    rx_pcs_top #(.num_lanes(nl)) DUT (.*);

    always #20 rx_clk_161_13 = ~rx_clk_161_13;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic next_rand64(output logic [63:0] value);
        lcg_state = lcg_next(lcg_state);
        value[63:32] = lcg_state;
        lcg_state = lcg_next(lcg_state);
        value[31:0] = lcg_state;
    endtask

    // Serial x^58 + x^39 + 1 scrambler, bit 0 sent first
    function automatic logic [63:0] scramble_block(input logic [63:0] plain,
                                                   input logic [63:0] prev);
        logic [127:0] s;
        s = {64'h0, prev};
        for (int i = 0; i < 64; i++) begin
            s[64+i] = plain[i] ^ s[64+i-39] ^ s[64+i-58];
        end
        return s[127:64];
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "Stopping on the first error");
    endtask

    // Plaintext block of one kind and its XGMII form {ctrl, data}
    task automatic build_block(input logic [3:0] kind, inout logic [63:0] pl,
                               output logic [1:0] hdr, output logic [71:0] xg);
        int k;
        k = int'(kind[2:0]);
        hdr = rx_pcs_pkg::HDR_CTRL;
        xg = {8'hFF, {8{rx_pcs_pkg::XG_ERROR}}};
        if (kind[3]) begin
            pl[7:0] = rx_pcs_pkg::BT_TERM[k];
            xg = {8'hFF << k, {8{rx_pcs_pkg::XG_IDLE}}};
            xg[8*k +: 8] = rx_pcs_pkg::XG_TERM;
            for (int j = 0; j < k; j++) begin
                xg[8*j +: 8] = pl[8*j+8 +: 8];
            end
        end else if (kind == kind_data) begin
            hdr = rx_pcs_pkg::HDR_DATA;
            xg = {8'h00, pl};
        end else if (kind == kind_idle) begin
            pl[7:0] = rx_pcs_pkg::BT_IDLE;
            xg = {8'hFF, {8{rx_pcs_pkg::XG_IDLE}}};
        end else if (kind == kind_start) begin
            pl[7:0] = rx_pcs_pkg::BT_START;
            xg = {8'h01, pl[63:8], rx_pcs_pkg::XG_START};
        end else begin
            hdr = {2{kind == kind_bad11}};
        end
    endtask

    task automatic send_word(input logic [nl-1:0][3:0] kinds, input bit check);
        logic [63:0]      pl;
        logic [1:0]       hdr;
        logic [71:0]      xg;
        logic [nl*64-1:0] exp_d;
        logic [nl*8-1:0]  exp_c;
        bit               term_seen;
        term_seen = 1'b0;
        @(negedge rx_clk_161_13);
        for (int l = 0; l < nl; l++) begin
            next_rand64(pl);
            build_block(kinds[l], pl, hdr, xg);
            // Data after a terminate in a lower lane
            if (term_seen && kinds[l] == kind_data) begin
                xg = {8'hFF, {8{rx_pcs_pkg::XG_ERROR}}};
            end
            term_seen = term_seen | kinds[l][3];
            exp_d[64*l +: 64] = xg[63:0];
            exp_c[8*l +: 8] = xg[71:64];
            rx_header_i[l] = hdr;
            rx_data_i[l] = bypass_descram_i ? pl : scramble_block(pl, wire_hist);
            wire_hist = rx_data_i[l];
        end
        block_valid_i = 1'b1;
        exp_q.push_back({check, exp_c, exp_d});
        words_sent++;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge rx_clk_161_13);
            block_valid_i = 1'b0;
            rx_header_i = '0;
        end
    endtask

    //////////////////////////////////////////////////
    // Output check, timeout and assertion watch
    //////////////////////////////////////////////////
    always @(negedge rx_clk_161_13) begin
        cycles++;
        if (cycles > max_cycles) begin
            fail_run($sformatf("Timeout after %0d clock cycles, test did not finish", cycles));
        end else if (DUT.u_asserts.fail_count != 0) begin
            fail_run("An assertion bound to the DUT ports failed");
        end else if (async_reset_n && xgmii_valid_o) begin
            if (exp_q.size() == 0) begin
                fail_run("The DUT produced an XGMII word that was never sent");
            end else begin
                got = exp_q.pop_front();
                words_seen++;
                if (got[nl*72] && {xgmii_rxc_o, xgmii_rxd_o} !== got[nl*72-1:0]) begin
                    fail_run($sformatf(
                        "CHECK FAILED at %0t: word %0d rxd %h rxc %h, expected rxd %h rxc %h",
                        $time, words_seen, xgmii_rxd_o, xgmii_rxc_o,
                        got[nl*64-1:0], got[nl*72-1:nl*64]));
                end
            end
        end
    end

    initial begin
        async_reset_n = 1'b0;
        block_valid_i = 1'b0;
        rx_header_i = '0;
        rx_data_i = '0;
        bypass_descram_i = 1'b0;
        clear_errblk_i = 1'b0;
        lcg_state = 32'h0c08804c;
        // Line history differs from the DUT's zero history
        next_rand64(wire_hist);
        repeat (16) @(negedge rx_clk_161_13);
        async_reset_n = 1'b1;
        idle_cycles(2);

        // Scrambled data with gaps, first word unchecked
        for (int i = 0; i < 60; i++) begin
            send_word({nl{kind_data}}, i != 0);
            if (i == 7 || lcg_state[29:27] == 3'd0) begin
                idle_cycles(1);
            end
        end

        // Control blocks and terminate chain, lane 3 written first
        send_word({kind_idle, kind_idle, kind_idle, kind_idle}, 1'b1);
        send_word({kind_data, kind_data, kind_start, kind_idle}, 1'b1);
        for (int k = 0; k < 8; k++) begin
            send_word({kind_data, kind_idle, kind_term0 | 4'(k), kind_data}, 1'b1);
        end
        send_word({kind_term0 | 4'd3, kind_data, kind_data, kind_start}, 1'b1);
        send_word({kind_data, kind_bad00, kind_data, kind_term0}, 1'b1);
        send_word({kind_data, kind_start, kind_idle, kind_bad11}, 1'b1);

        // Raw words with the descrambler bypassed
        idle_cycles(3);
        bypass_descram_i = 1'b1;
        for (int i = 0; i < 8; i++) begin
            send_word({nl{kind_data}}, 1'b1);
        end
        idle_cycles(3);
        bypass_descram_i = 1'b0;

        // 264 bad lanes saturate the counter, then a clear
        repeat (66) send_word({kind_bad11, kind_bad00, kind_bad11, kind_bad00}, 1'b1);
        idle_cycles(4);
        @(negedge rx_clk_161_13);
        clear_errblk_i = 1'b1;
        @(negedge rx_clk_161_13);
        clear_errblk_i = 1'b0;
        send_word({kind_data, kind_data, kind_bad00, kind_data}, 1'b1);
        send_word({kind_data, kind_term0 | 4'd5, kind_bad11, kind_data}, 1'b1);
        idle_cycles(5);

        while (exp_q.size() != 0) begin
            @(negedge rx_clk_161_13);
        end
        @(negedge rx_clk_161_13);
        if (words_seen == words_sent && DUT.u_asserts.fail_count == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            fail_run($sformatf("Run ended with %0d of %0d words seen",
                               words_seen, words_sent));
        end
    end

endmodule

`default_nettype wire

// File: build.f
logic/rx_pcs_pkg.sv
logic/lane_block_capture.sv
logic/parallel_descrambler.sv
logic/block_decoder.sv
logic/xgmii_word_assembler.sv
logic/rx_pcs_top.sv
tb/rx_pcs_asserts.sv
tb/rx_pcs_tb.sv
